//--- common/cpuPkg.sv
package cpuPkg;

  localparam int DATA_WIDTH = 32;
  localparam int REG_COUNT = 16;
  localparam int IP_REG = 15;
  localparam int STATE_WIDTH = 4;
  localparam int IDX_WIDTH = 4;
  localparam int OPCODE_WIDTH = 4;
  localparam int FLAGS_WIDTH = 2;
  localparam int IMM_WIDTH = 12;

  // instruction sequencing states.
  localparam logic [STATE_WIDTH-1:0] WAIT_FOR_START = 4'd0;
  localparam logic [STATE_WIDTH-1:0] FETCH = 4'd1;
  localparam logic [STATE_WIDTH-1:0] WRITE_REG_IP = 4'd2;
  localparam logic [STATE_WIDTH-1:0] READ_COND = 4'd3;
  localparam logic [STATE_WIDTH-1:0] READ_COND_P = 4'd4;
  localparam logic [STATE_WIDTH-1:0] READ_SRC1 = 4'd5;
  localparam logic [STATE_WIDTH-1:0] READ_SRC1_P = 4'd6;
  localparam logic [STATE_WIDTH-1:0] READ_SRC0 = 4'd7;
  localparam logic [STATE_WIDTH-1:0] READ_SRC0_P = 4'd8;
  localparam logic [STATE_WIDTH-1:0] ALU_BEGIN = 4'd9;
  localparam logic [STATE_WIDTH-1:0] WRITE_DST = 4'd10;
  localparam logic [STATE_WIDTH-1:0] FINISH = 4'd11;

  localparam logic [OPCODE_WIDTH-1:0] OP_ADD = 4'd0;
  localparam logic [OPCODE_WIDTH-1:0] OP_SUB = 4'd1;
  localparam logic [OPCODE_WIDTH-1:0] OP_AND = 4'd2;
  localparam logic [OPCODE_WIDTH-1:0] OP_OR = 4'd3;
  localparam logic [OPCODE_WIDTH-1:0] OP_XOR = 4'd4;
  localparam logic [OPCODE_WIDTH-1:0] OP_SHL = 4'd5;
  localparam logic [OPCODE_WIDTH-1:0] OP_SHR = 4'd6;
  localparam logic [OPCODE_WIDTH-1:0] OP_MOV = 4'd7;
  localparam logic [OPCODE_WIDTH-1:0] OP_LDI = 4'd8;
  localparam logic [OPCODE_WIDTH-1:0] OP_HALT = 4'd15;

  localparam logic [FLAGS_WIDTH-1:0] FLAGS_ABSENT = 2'b11;

  // instruction word layout.
  localparam int DST_IDX_LSB = 0;
  localparam int S1_IDX_LSB = 4;
  localparam int S0_IDX_LSB = 8;
  localparam int COND_IDX_LSB = 12;
  localparam int IMM_LSB = 4;
  localparam int S1_PTR_BIT = 16;
  localparam int S0_PTR_BIT = 17;
  localparam int DST_PTR_BIT = 18;
  localparam int COND_PTR_BIT = 19;
  localparam int S1_FLAGS_LSB = 20;
  localparam int S0_FLAGS_LSB = 22;
  localparam int DST_FLAGS_LSB = 24;
  localparam int COND_FLAGS_LSB = 26;
  localparam int OPCODE_LSB = 28;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [cpuPkg::OPCODE_WIDTH-1:0] op,
  input  logic [cpuPkg::DATA_WIDTH-1:0]   a,
  input  logic [cpuPkg::DATA_WIDTH-1:0]   b,
  output logic [cpuPkg::DATA_WIDTH-1:0]   result
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      cpuPkg::OP_ADD: result = a + b;
      cpuPkg::OP_SUB: result = a - b;
      cpuPkg::OP_AND: result = a & b;
      cpuPkg::OP_OR:  result = a | b;
      cpuPkg::OP_XOR: result = a ^ b;
      cpuPkg::OP_SHL: result = a << shamt;
      // logical, no sign fill.
      cpuPkg::OP_SHR: result = a >> shamt;
      cpuPkg::OP_MOV: result = a;
      default:        result = '0;
    endcase
  end

endmodule

//--- core/stateManager.sv
`timescale 1ns/1ps

module stateManager (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [cpuPkg::DATA_WIDTH-1:0]  command,
  input  logic [cpuPkg::DATA_WIDTH-1:0]  cond,
  input  logic                           stepDone,
  output logic [cpuPkg::STATE_WIDTH-1:0] state,
  output logic                           halted
);

  logic                             s1Ptr;
  logic                             s0Ptr;
  logic                             condPtr;
  logic [cpuPkg::FLAGS_WIDTH-1:0]   s1Flags;
  logic [cpuPkg::FLAGS_WIDTH-1:0]   s0Flags;
  logic [cpuPkg::FLAGS_WIDTH-1:0]   condFlags;
  logic [cpuPkg::OPCODE_WIDTH-1:0]  opcode;
  logic [cpuPkg::STATE_WIDTH-1:0]   nextState;
  logic                             advance;

  assign s1Ptr = command[cpuPkg::S1_PTR_BIT];
  assign s0Ptr = command[cpuPkg::S0_PTR_BIT];
  assign condPtr = command[cpuPkg::COND_PTR_BIT];
  assign s1Flags = command[cpuPkg::S1_FLAGS_LSB +: cpuPkg::FLAGS_WIDTH];
  assign s0Flags = command[cpuPkg::S0_FLAGS_LSB +: cpuPkg::FLAGS_WIDTH];
  assign condFlags = command[cpuPkg::COND_FLAGS_LSB +: cpuPkg::FLAGS_WIDTH];
  assign opcode = command[cpuPkg::OPCODE_LSB +: cpuPkg::OPCODE_WIDTH];

  // idle state waits for start, every other state for its step.
  assign advance = (state == cpuPkg::WAIT_FOR_START) ? start : stepDone;

  always_comb begin
    nextState = state;
    case (state)
      cpuPkg::WAIT_FOR_START: nextState = cpuPkg::FETCH;
      cpuPkg::FETCH:          nextState = cpuPkg::WRITE_REG_IP;
      cpuPkg::WRITE_REG_IP: begin
        if (opcode == cpuPkg::OP_HALT) begin
          nextState = cpuPkg::WAIT_FOR_START;
        end else if (opcode == cpuPkg::OP_LDI) begin
          nextState = cpuPkg::WRITE_DST;
        end else if (condFlags == cpuPkg::FLAGS_ABSENT) begin
          nextState = cpuPkg::READ_SRC1;
        end else begin
          nextState = cpuPkg::READ_COND;
        end
      end
      cpuPkg::READ_COND: begin
        if (condPtr) begin
          nextState = cpuPkg::READ_COND_P;
        end else if (cond == '0) begin
          nextState = cpuPkg::FINISH;
        end else begin
          nextState = cpuPkg::READ_SRC1;
        end
      end
      // cond here is the word fetched through the pointer.
      cpuPkg::READ_COND_P: begin
        nextState = (cond == '0) ? cpuPkg::FINISH : cpuPkg::READ_SRC1;
      end
      cpuPkg::READ_SRC1: begin
        if (s1Flags != cpuPkg::FLAGS_ABSENT && s1Ptr) begin
          nextState = cpuPkg::READ_SRC1_P;
        end else begin
          nextState = cpuPkg::READ_SRC0;
        end
      end
      cpuPkg::READ_SRC1_P: nextState = cpuPkg::READ_SRC0;
      cpuPkg::READ_SRC0: begin
        if (s0Flags != cpuPkg::FLAGS_ABSENT && s0Ptr) begin
          nextState = cpuPkg::READ_SRC0_P;
        end else begin
          nextState = cpuPkg::ALU_BEGIN;
        end
      end
      cpuPkg::READ_SRC0_P: nextState = cpuPkg::ALU_BEGIN;
      cpuPkg::ALU_BEGIN:   nextState = cpuPkg::WRITE_DST;
      cpuPkg::WRITE_DST:   nextState = cpuPkg::FINISH;
      cpuPkg::FINISH:      nextState = cpuPkg::FETCH;
      default:             nextState = cpuPkg::WAIT_FOR_START;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cpuPkg::WAIT_FOR_START;
      halted <= 1'b0;
    end else begin
      if (advance) begin
        state <= nextState;
      end
      halted <= advance && state == cpuPkg::WRITE_REG_IP && opcode == cpuPkg::OP_HALT;
    end
  end

  // codes above FINISH are never reached.
  assert property (@(posedge clk) disable iff (rst) state <= cpuPkg::FINISH);

endmodule

//--- core/datapath.sv
`timescale 1ns/1ps

module datapath #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [cpuPkg::STATE_WIDTH-1:0] state,
  output logic [cpuPkg::DATA_WIDTH-1:0]  command,
  output logic [cpuPkg::DATA_WIDTH-1:0]  cond,
  output logic                           stepDone,
  output logic                           coreReq,
  output logic                           coreWe,
  output logic [ADDR_WIDTH-1:0]          coreAddr,
  output logic [cpuPkg::DATA_WIDTH-1:0]  coreWdata,
  input  logic                           coreDone,
  input  logic [cpuPkg::DATA_WIDTH-1:0]  coreRdata
);

  logic [cpuPkg::DATA_WIDTH-1:0]   regs [cpuPkg::REG_COUNT];
  logic [cpuPkg::DATA_WIDTH-1:0]   ir;
  logic [cpuPkg::DATA_WIDTH-1:0]   condQ;
  logic [cpuPkg::DATA_WIDTH-1:0]   src1Q;
  logic [cpuPkg::DATA_WIDTH-1:0]   src0Q;
  logic [cpuPkg::DATA_WIDTH-1:0]   aluQ;
  logic [cpuPkg::DATA_WIDTH-1:0]   aluResult;
  logic [cpuPkg::DATA_WIDTH-1:0]   imm;
  logic [cpuPkg::DATA_WIDTH-1:0]   wrData;
  logic [cpuPkg::OPCODE_WIDTH-1:0] opcode;
  logic [cpuPkg::IDX_WIDTH-1:0]    condIdx;
  logic [cpuPkg::IDX_WIDTH-1:0]    src0Idx;
  logic [cpuPkg::IDX_WIDTH-1:0]    src1Idx;
  logic [cpuPkg::IDX_WIDTH-1:0]    dstIdx;
  logic                            src1Absent;
  logic                            src0Absent;
  logic                            dstAbsent;
  logic                            dstPtr;
  logic                            dstMem;
  logic                            memState;
  logic                            outstanding;

  assign command = ir;
  assign opcode = ir[cpuPkg::OPCODE_LSB +: cpuPkg::OPCODE_WIDTH];
  assign condIdx = ir[cpuPkg::COND_IDX_LSB +: cpuPkg::IDX_WIDTH];
  assign src0Idx = ir[cpuPkg::S0_IDX_LSB +: cpuPkg::IDX_WIDTH];
  assign src1Idx = ir[cpuPkg::S1_IDX_LSB +: cpuPkg::IDX_WIDTH];
  assign dstIdx = ir[cpuPkg::DST_IDX_LSB +: cpuPkg::IDX_WIDTH];
  assign src1Absent = ir[cpuPkg::S1_FLAGS_LSB +: cpuPkg::FLAGS_WIDTH] == cpuPkg::FLAGS_ABSENT;
  assign src0Absent = ir[cpuPkg::S0_FLAGS_LSB +: cpuPkg::FLAGS_WIDTH] == cpuPkg::FLAGS_ABSENT;
  assign dstAbsent = ir[cpuPkg::DST_FLAGS_LSB +: cpuPkg::FLAGS_WIDTH] == cpuPkg::FLAGS_ABSENT;
  assign dstPtr = ir[cpuPkg::DST_PTR_BIT];
  assign dstMem = !dstAbsent && dstPtr;

  assign imm = {{(cpuPkg::DATA_WIDTH - cpuPkg::IMM_WIDTH){1'b0}},
                ir[cpuPkg::IMM_LSB +: cpuPkg::IMM_WIDTH]};
  assign wrData = (opcode == cpuPkg::OP_LDI) ? imm : aluQ;

  alu alu_i (
    .op     (opcode),
    .a      (src1Q),
    .b      (src0Q),
    .result (aluResult)
  );

  assign memState = state == cpuPkg::FETCH || state == cpuPkg::READ_COND_P ||
                    state == cpuPkg::READ_SRC1_P || state == cpuPkg::READ_SRC0_P ||
                    (state == cpuPkg::WRITE_DST && dstMem);

  // one strobe per memory state.
  assign coreReq = memState && !outstanding;
  assign coreWe = state == cpuPkg::WRITE_DST;
  assign coreWdata = wrData;
  assign stepDone = (state == cpuPkg::WAIT_FOR_START) ? 1'b0 :
                    memState ? coreDone : 1'b1;

  always_comb begin
    case (state)
      cpuPkg::FETCH:       coreAddr = regs[cpuPkg::IP_REG][ADDR_WIDTH-1:0];
      cpuPkg::READ_COND_P: coreAddr = condQ[ADDR_WIDTH-1:0];
      cpuPkg::READ_SRC1_P: coreAddr = src1Q[ADDR_WIDTH-1:0];
      cpuPkg::READ_SRC0_P: coreAddr = src0Q[ADDR_WIDTH-1:0];
      default:             coreAddr = regs[dstIdx][ADDR_WIDTH-1:0];
    endcase
  end

  // the FSM decides in the same cycle the value arrives.
  always_comb begin
    case (state)
      cpuPkg::READ_COND:   cond = regs[condIdx];
      cpuPkg::READ_COND_P: cond = coreRdata;
      default:             cond = condQ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state == cpuPkg::WAIT_FOR_START && start) begin
      regs[cpuPkg::IP_REG] <= '0;
    end else if (state == cpuPkg::WRITE_REG_IP) begin
      regs[cpuPkg::IP_REG] <= regs[cpuPkg::IP_REG] + 1'b1;
    end else if (state == cpuPkg::WRITE_DST && !dstAbsent && !dstPtr) begin
      regs[dstIdx] <= wrData;
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      cpuPkg::FETCH:       if (coreDone) ir <= coreRdata;
      cpuPkg::READ_COND:   condQ <= regs[condIdx];
      cpuPkg::READ_COND_P: if (coreDone) condQ <= coreRdata;
      cpuPkg::READ_SRC1:   src1Q <= src1Absent ? '0 : regs[src1Idx];
      cpuPkg::READ_SRC1_P: if (coreDone) src1Q <= coreRdata;
      cpuPkg::READ_SRC0:   src0Q <= src0Absent ? '0 : regs[src0Idx];
      cpuPkg::READ_SRC0_P: if (coreDone) src0Q <= coreRdata;
      cpuPkg::ALU_BEGIN:   aluQ <= aluResult;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (coreReq) begin
      outstanding <= 1'b1;
    end else if (coreDone) begin
      outstanding <= 1'b0;
    end
  end

  // arbiter answers the next cycle and no strobe overlaps it.
  assert property (@(posedge clk) disable iff (rst) coreReq |=> coreDone && !coreReq);

endmodule

//--- hdl/memArbiter.sv
`timescale 1ns/1ps

module memArbiter #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          coreReq,
  input  logic                          coreWe,
  input  logic [ADDR_WIDTH-1:0]         coreAddr,
  input  logic [cpuPkg::DATA_WIDTH-1:0] coreWdata,
  output logic                          coreDone,
  output logic [cpuPkg::DATA_WIDTH-1:0] coreRdata,
  input  logic                          hostReq,
  input  logic                          hostWe,
  input  logic [ADDR_WIDTH-1:0]         hostAddr,
  input  logic [cpuPkg::DATA_WIDTH-1:0] hostWdata,
  output logic                          hostDone,
  output logic [cpuPkg::DATA_WIDTH-1:0] hostRdata,
  output logic                          ramEn,
  output logic                          ramWe,
  output logic [ADDR_WIDTH-1:0]         ramAddr,
  output logic [cpuPkg::DATA_WIDTH-1:0] ramWdata,
  input  logic [cpuPkg::DATA_WIDTH-1:0] ramRdata
);

  logic                          pendValid;
  logic                          pendWe;
  logic [ADDR_WIDTH-1:0]         pendAddr;
  logic [cpuPkg::DATA_WIDTH-1:0] pendWdata;
  logic                          issuedQ;
  logic                          ownerCore;

  // core first, then the held host request, then a fresh one.
  always_comb begin
    if (coreReq) begin
      ramWe = coreWe;
      ramAddr = coreAddr;
      ramWdata = coreWdata;
    end else if (pendValid) begin
      ramWe = pendWe;
      ramAddr = pendAddr;
      ramWdata = pendWdata;
    end else begin
      ramWe = hostWe && hostReq;
      ramAddr = hostAddr;
      ramWdata = hostWdata;
    end
  end

  assign ramEn = coreReq || pendValid || hostReq;

  always_ff @(posedge clk) begin
    if (rst) begin
      pendValid <= 1'b0;
      issuedQ <= 1'b0;
      ownerCore <= 1'b0;
    end else begin
      if (coreReq && hostReq) begin
        pendValid <= 1'b1;
      end else if (!coreReq) begin
        pendValid <= 1'b0;
      end
      issuedQ <= ramEn;
      ownerCore <= coreReq;
    end
  end

  always_ff @(posedge clk) begin
    if (hostReq) begin
      pendWe <= hostWe;
      pendAddr <= hostAddr;
      pendWdata <= hostWdata;
    end
  end

  assign coreDone = issuedQ && ownerCore;
  assign hostDone = issuedQ && !ownerCore;
  assign coreRdata = ramRdata;
  assign hostRdata = ramRdata;

  // host has to wait for hostDone, so a held request blocks it.
  assert property (@(posedge clk) disable iff (rst) pendValid |-> !hostReq);

endmodule

//--- hdl/dataRam.sv
`timescale 1ns/1ps

module dataRam #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                          clk,
  input  logic                          en,
  input  logic                          we,
  input  logic [ADDR_WIDTH-1:0]         addr,
  input  logic [cpuPkg::DATA_WIDTH-1:0] wdata,
  output logic [cpuPkg::DATA_WIDTH-1:0] rdata
);

  logic [cpuPkg::DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // read returns the old word on a write.
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];
    end
  end

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  output logic                          halted,
  input  logic                          hostReq,
  input  logic                          hostWe,
  input  logic [ADDR_WIDTH-1:0]         hostAddr,
  input  logic [cpuPkg::DATA_WIDTH-1:0] hostWdata,
  output logic                          hostDone,
  output logic [cpuPkg::DATA_WIDTH-1:0] hostRdata
);

  logic [cpuPkg::STATE_WIDTH-1:0] state;
  logic [cpuPkg::DATA_WIDTH-1:0]  command;
  logic [cpuPkg::DATA_WIDTH-1:0]  cond;
  logic                           stepDone;
  logic                           coreReq;
  logic                           coreWe;
  logic [ADDR_WIDTH-1:0]          coreAddr;
  logic [cpuPkg::DATA_WIDTH-1:0]  coreWdata;
  logic                           coreDone;
  logic [cpuPkg::DATA_WIDTH-1:0]  coreRdata;
  logic                           ramEn;
  logic                           ramWe;
  logic [ADDR_WIDTH-1:0]          ramAddr;
  logic [cpuPkg::DATA_WIDTH-1:0]  ramWdata;
  logic [cpuPkg::DATA_WIDTH-1:0]  ramRdata;

  stateManager stateManager_i (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .command  (command),
    .cond     (cond),
    .stepDone (stepDone),
    .state    (state),
    .halted   (halted)
  );

  datapath #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) datapath_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .state     (state),
    .command   (command),
    .cond      (cond),
    .stepDone  (stepDone),
    .coreReq   (coreReq),
    .coreWe    (coreWe),
    .coreAddr  (coreAddr),
    .coreWdata (coreWdata),
    .coreDone  (coreDone),
    .coreRdata (coreRdata)
  );

  memArbiter #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) memArbiter_i (
    .clk       (clk),
    .rst       (rst),
    .coreReq   (coreReq),
    .coreWe    (coreWe),
    .coreAddr  (coreAddr),
    .coreWdata (coreWdata),
    .coreDone  (coreDone),
    .coreRdata (coreRdata),
    .hostReq   (hostReq),
    .hostWe    (hostWe),
    .hostAddr  (hostAddr),
    .hostWdata (hostWdata),
    .hostDone  (hostDone),
    .hostRdata (hostRdata),
    .ramEn     (ramEn),
    .ramWe     (ramWe),
    .ramAddr   (ramAddr),
    .ramWdata  (ramWdata),
    .ramRdata  (ramRdata)
  );

  dataRam #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) dataRam_i (
    .clk   (clk),
    .en    (ramEn),
    .we    (ramWe),
    .addr  (ramAddr),
    .wdata (ramWdata),
    .rdata (ramRdata)
  );

endmodule

//--- dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

  localparam int ADDR_WIDTH = 8;
  localparam int HOST_TIMEOUT = 20;
  localparam int RUN_TIMEOUT = 4000;

  logic                          clk;
  logic                          rst;
  logic                          start;
  logic                          halted;
  logic                          hostReq;
  logic                          hostWe;
  logic [ADDR_WIDTH-1:0]         hostAddr;
  logic [cpuPkg::DATA_WIDTH-1:0] hostWdata;
  logic                          hostDone;
  logic [cpuPkg::DATA_WIDTH-1:0] hostRdata;

  logic [31:0]                   lfsr;
  int                            errors;
  int                            tests;
  logic [ADDR_WIDTH-1:0]         bgAddr [$];
  logic [cpuPkg::DATA_WIDTH-1:0] bgData [$];

  cpuTop #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) cpuTop_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .halted    (halted),
    .hostReq   (hostReq),
    .hostWe    (hostWe),
    .hostAddr  (hostAddr),
    .hostWdata (hostWdata),
    .hostDone  (hostDone),
    .hostRdata (hostRdata)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // one lfsr step per bit taken.
  task automatic takeBits(input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      value = (value << 1) | lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
  endtask

  // hostDone may already show on the first falling edge after the strobe.
  task automatic hostAccess(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [cpuPkg::DATA_WIDTH-1:0] wdata,
                            output logic [cpuPkg::DATA_WIDTH-1:0] rdata,
                            output logic done);
    int n;
    @(negedge clk);
    hostReq = 1'b1;
    hostWe = we;
    hostAddr = addr;
    hostWdata = wdata;
    done = 1'b0;
    rdata = '0;
    for (n = 0; n < HOST_TIMEOUT && !done; n++) begin
      @(negedge clk);
      hostReq = 1'b0;
      if (hostDone) begin
        done = 1'b1;
        rdata = hostRdata;
      end
    end
    hostReq = 1'b0;
  endtask

  task automatic writeWord(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        done;
    hostAccess(1'b1, addr, data, unused, done);
    assert (done) else begin
      $display("host write to %h never got hostDone", addr);
      errors++;
    end
  endtask

  task automatic checkWord(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] expected,
                           input string name);
    logic [31:0] got;
    logic        done;
    tests++;
    hostAccess(1'b0, addr, '0, got, done);
    assert (done) else begin
      $display("%s: host read of %h never got hostDone", name, addr);
      errors++;
    end
    if (done) begin
      assert (got == expected) $display("PASS %s", name);
      else begin
        $display("FAIL %s expected %h actual %h", name, expected, got);
        errors++;
      end
    end
  endtask

  // queued host writes go out at random moments while the core runs.
  task automatic runProgram(input string name);
    int          cycles;
    int          gap;
    int          writes;
    logic        seen;
    logic        done;
    logic [31:0] unused;
    tests++;
    cycles = 0;
    writes = 0;
    seen = 1'b0;
    @(negedge clk);
    start = 1'b1;
    fork
      begin
        @(negedge clk);
        start = 1'b0;
      end
      begin
        while (bgAddr.size() > 0) begin
          // the first write meets the strobe of the first fetch.
          if (writes > 0) begin
            takeBits(4, gap);
            repeat (gap) @(negedge clk);
          end
          hostAccess(1'b1, bgAddr.pop_front(), bgData.pop_front(), unused, done);
          writes++;
          assert (done) else begin
            $display("%s: host write during the run never got hostDone", name);
            errors++;
          end
        end
      end
      begin
        while (!seen && cycles < RUN_TIMEOUT) begin
          @(negedge clk);
          cycles++;
          seen = halted;
        end
      end
    join
    assert (seen) $display("PASS %s halted after %0d cycles, %0d host writes", name,
                           cycles, writes);
    else begin
      $display("%s: core did not halt within %0d cycles", name, RUN_TIMEOUT);
      errors++;
    end
  endtask

  initial begin
    int                    fd;
    int                    n;
    string                 tok;
    string                 name;
    string                 rest;
    logic [ADDR_WIDTH-1:0] addr;
    logic [31:0]           data;
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    hostReq = 1'b0;
    hostWe = 1'b0;
    hostAddr = '0;
    hostWdata = '0;
    lfsr = 32'h7a53_c172;
    errors = 0;
    tests = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    fd = $fopen("dv/progCases.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/progCases.txt");
      errors++;
    end else begin
      while ($fscanf(fd, " %s", tok) == 1) begin
        if (tok.substr(0, 0) == "#") begin
          n = $fgets(rest, fd);
        end else if (tok == "W" || tok == "D") begin
          n = $fscanf(fd, " %h %h", addr, data);
          if (n != 2) begin
            $display("malformed %s record in the cases file", tok);
            errors++;
          end else if (tok == "W") begin
            writeWord(addr, data);
          end else begin
            bgAddr.push_back(addr);
            bgData.push_back(data);
          end
        end else if (tok == "R") begin
          n = $fscanf(fd, " %h %h %s", addr, data, name);
          if (n != 3) begin
            $display("malformed R record in the cases file");
            errors++;
          end else begin
            checkWord(addr, data, name);
          end
        end else if (tok == "S") begin
          n = $fscanf(fd, " %s", name);
          runProgram(name);
        end else begin
          $display("unknown record type %s in the cases file", tok);
          errors++;
        end
      end
      $fclose(fd);
    end
    $display("%0d tests, %0d errors", tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- dv/progCases.txt
# W addr data | R addr expected name | S name | D addr data (host write during next S)
# all numbers hex; program at 00, operands at 60, results at 80, host-only area at C0
W 00 80006B41
W 01 80000C32
W 02 80000000
W 03 80000604
W 04 80000615
W 05 80000626
W 06 80000803
W 07 0C040213
W 08 80000813
W 09 1C040213
W 0A 80000823
W 0B 2C040213
W 0C 80000833
W 0D 3C040213
W 0E 80000843
W 0F 4C040213
W 10 80000853
W 11 5C040213
W 12 80000863
W 13 6C040213
W 14 80000873
W 15 1C070543
W 16 80000883
W 17 00040213
W 18 80000893
W 19 400C6213
W 1A 800008A3
W 1B 0CC40213
W 1C F0000000
W 60 000006B4
W 61 000000C3
W 62 00000100
W 88 0BADF00D
R 60 000006B4 preloadA
R 61 000000C3 preloadB
R 88 0BADF00D skipInit
R 15 1C070543 progWord
S firstRun
R 80 00000777 addReg
R 81 000005F1 subReg
R 82 00000080 andReg
R 83 000006F7 orReg
R 84 00000677 xorReg
R 85 000035A0 shlReg
R 86 000000D6 shrReg
R 87 000005F1 subPtr
R 88 0BADF00D condZeroSkip
R 89 00000677 condPtrRun
R 8A 000006B4 src0Absent
R 62 00000100 dataKept
W 80 00000000
W 86 00000000
W 89 00000000
D C0 13579BDF
D C1 2468ACE0
D C2 0F1E2D3C
D C3 A5A55A5A
S busyRun
R 80 00000777 addRerun
R 86 000000D6 shrRerun
R 89 00000677 condPtrRerun
R C0 13579BDF bgWrite0
R C1 2468ACE0 bgWrite1
R C2 0F1E2D3C bgWrite2
R C3 A5A55A5A bgWrite3

//--- vlog.f
common/cpuPkg.sv
hdl/alu.sv
core/stateManager.sv
core/datapath.sv
hdl/memArbiter.sv
hdl/dataRam.sv
hdl/cpuTop.sv
dv/cpuTb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - common/cpuPkg.sv
  - hdl/alu.sv
  - core/stateManager.sv
  - core/datapath.sv
  - hdl/memArbiter.sv
  - hdl/dataRam.sv
  - hdl/cpuTop.sv
  - target: simulation
    files:
      - dv/cpuTb.sv
